/* common/ao_bus_pkg.sv */
// --------------------
// Always-on bus package
// OBI and register bus widths and the address map
// --------------------

package ao_bus_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Word offset inside a peripheral, address bits 7 to 2
  localparam int unsigned OFFS_W   = 6;
  localparam int unsigned OFFS_LSB = 2;

  // Peripheral region, address bits 15 to 12
  localparam int unsigned REGION_W   = 4;
  localparam int unsigned REGION_LSB = 12;

  localparam logic [REGION_W-1:0] REGION_SOC_CTRL = 4'd0;
  localparam logic [REGION_W-1:0] REGION_TIMER    = 4'd1;
  localparam logic [REGION_W-1:0] REGION_POWER    = 4'd2;

  typedef enum logic [1:0] {
    SEL_SOC_CTRL = 2'd0,
    SEL_TIMER    = 2'd1,
    SEL_POWER    = 2'd2,
    SEL_NONE     = 2'd3
  } periph_sel_e;

endpackage

/* common/ao_periph_pkg.sv */
// --------------------
// Peripheral register map
// Offsets, reset values and power states
// --------------------

package ao_periph_pkg;

  import ao_bus_pkg::*;

  // SoC control
  localparam logic [OFFS_W-1:0] SOC_EXIT_VALID = 6'd0;
  localparam logic [OFFS_W-1:0] SOC_EXIT_VALUE = 6'd1;
  localparam logic [OFFS_W-1:0] SOC_BOOT_SEL   = 6'd2;
  localparam logic [OFFS_W-1:0] SOC_SCRATCH    = 6'd3;

  // Machine timer
  localparam logic [OFFS_W-1:0] TMR_CTRL     = 6'd0;
  localparam logic [OFFS_W-1:0] TMR_PRESCALE = 6'd1;
  localparam logic [OFFS_W-1:0] TMR_MTIME    = 6'd2;
  localparam logic [OFFS_W-1:0] TMR_MTIMECMP = 6'd3;

  // Power manager
  localparam logic [OFFS_W-1:0] PWR_CTRL       = 6'd0;
  localparam logic [OFFS_W-1:0] PWR_WAKE_DELAY = 6'd1;
  localparam logic [OFFS_W-1:0] PWR_STATUS     = 6'd2;

  localparam logic [DATA_W-1:0] MTIMECMP_RST   = '1;
  localparam logic [DATA_W-1:0] WAKE_DELAY_RST = 32'd4;

  typedef enum logic [1:0] {
    PWR_ACTIVE = 2'd0,
    PWR_OFF    = 2'd1,
    PWR_WAKE   = 2'd2
  } power_state_e;

endpackage

/* common/reg_bus_if.sv */
// --------------------
// Register bus
// Single-master strobe bus to one peripheral
// --------------------

interface reg_bus_if
  import ao_bus_pkg::*;
();

  logic              valid;
  logic              write;
  logic [OFFS_W-1:0] offs;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] rdata;
  logic              error;

  modport host(output valid, write, offs, wdata, input rdata, error);

  modport device(input valid, write, offs, wdata, output rdata, error);

endinterface

/* files.f */
common/ao_bus_pkg.sv
common/ao_periph_pkg.sv
common/reg_bus_if.sv
verilog/obi_reg_bridge.sv
verilog/soc_ctrl.sv
rv_timer/rv_timer.sv
power_manager/power_manager.sv
verilog/ao_periph.sv
verif/tb_clk_gen.sv
verif/ao_periph_props.sv
verif/ao_periph_checker.sv
verif/ao_periph_tb.sv

/* power_manager/power_manager.sv */
// --------------------
// Power manager
// Sleep and wake sequencing of the CPU switch and reset
// --------------------

module power_manager
  import ao_bus_pkg::*;
  import ao_periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  reg_bus_if.device bus_i,
  input  logic      core_sleep_i,
  input  logic      wake_irq_i,
  output logic      powergate_switch_o,
  output logic      cpu_rst_no
);

  power_state_e      state_q;
  logic              sleep_en_q;
  logic [DATA_W-1:0] wake_delay_q;
  logic [DATA_W-1:0] delay_cnt_q;
  logic [DATA_W-1:0] rdata;
  logic              err;
  logic              wr_en;

  always_comb begin
    rdata = '0;
    err   = 1'b0;
    case (bus_i.offs)
      PWR_CTRL:       rdata = {{(DATA_W-1){1'b0}}, sleep_en_q};
      PWR_WAKE_DELAY: rdata = wake_delay_q;
      PWR_STATUS: begin
        rdata = {{(DATA_W-2){1'b0}}, state_q};
        err   = bus_i.write;
      end
      default:        err = 1'b1;
    endcase
  end

  assign wr_en = bus_i.valid && bus_i.write && !err;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sleep_en_q   <= 1'b0;
      wake_delay_q <= WAKE_DELAY_RST;
    end else if (wr_en) begin
      if (bus_i.offs == PWR_CTRL) sleep_en_q <= bus_i.wdata[0];
      if (bus_i.offs == PWR_WAKE_DELAY) wake_delay_q <= bus_i.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= PWR_ACTIVE;
      delay_cnt_q <= '0;
    end else begin
      case (state_q)
        PWR_ACTIVE: begin
          if (sleep_en_q && core_sleep_i) state_q <= PWR_OFF;
        end
        PWR_OFF: begin
          if (wake_irq_i) begin
            state_q     <= PWR_WAKE;
            delay_cnt_q <= '0;
          end
        end
        PWR_WAKE: begin
          // CPU stays in reset while power settles
          if (delay_cnt_q >= wake_delay_q) begin
            state_q <= PWR_ACTIVE;
          end else begin
            delay_cnt_q <= delay_cnt_q + 1'b1;
          end
        end
        default: state_q <= PWR_ACTIVE;
      endcase
    end
  end

  assign powergate_switch_o = (state_q == PWR_OFF);
  assign cpu_rst_no         = (state_q == PWR_ACTIVE);
  assign bus_i.rdata        = rdata;
  assign bus_i.error        = err;

endmodule

/* rv_timer/rv_timer.sv */
// --------------------
// Machine timer
// Prescaled 32-bit counter with compare interrupt
// --------------------

module rv_timer
  import ao_bus_pkg::*;
  import ao_periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  reg_bus_if.device bus_i,
  output logic      irq_o
);

  logic              enable_q;
  logic [DATA_W-1:0] prescale_q;
  logic [DATA_W-1:0] presc_cnt_q;
  logic [DATA_W-1:0] mtime_q;
  logic [DATA_W-1:0] mtimecmp_q;
  logic              irq_q;
  logic [DATA_W-1:0] rdata;
  logic              err;
  logic              wr_en;
  logic              tick;

  always_comb begin
    rdata = '0;
    err   = 1'b0;
    case (bus_i.offs)
      TMR_CTRL:     rdata = {{(DATA_W-1){1'b0}}, enable_q};
      TMR_PRESCALE: rdata = prescale_q;
      TMR_MTIME:    rdata = mtime_q;
      TMR_MTIMECMP: rdata = mtimecmp_q;
      default:      err = 1'b1;
    endcase
  end

  assign wr_en = bus_i.valid && bus_i.write && !err;

  // >= keeps the counter sane if the limit is lowered mid-count
  assign tick = enable_q && (presc_cnt_q >= prescale_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      enable_q    <= 1'b0;
      prescale_q  <= '0;
      presc_cnt_q <= '0;
      mtime_q     <= '0;
      mtimecmp_q  <= MTIMECMP_RST;
      irq_q       <= 1'b0;
    end else begin
      if (wr_en && bus_i.offs == TMR_MTIME) begin
        mtime_q     <= bus_i.wdata;
        presc_cnt_q <= '0;
      end else if (tick) begin
        mtime_q     <= mtime_q + 1'b1;
        presc_cnt_q <= '0;
      end else if (enable_q) begin
        presc_cnt_q <= presc_cnt_q + 1'b1;
      end
      if (wr_en && bus_i.offs == TMR_CTRL) begin
        enable_q <= bus_i.wdata[0];
      end
      if (wr_en && bus_i.offs == TMR_PRESCALE) begin
        prescale_q <= bus_i.wdata;
      end
      if (wr_en && bus_i.offs == TMR_MTIMECMP) begin
        mtimecmp_q <= bus_i.wdata;
      end
      irq_q <= enable_q && (mtime_q >= mtimecmp_q);
    end
  end

  assign bus_i.rdata = rdata;
  assign bus_i.error = err;
  assign irq_o       = irq_q;

endmodule

/* verif/ao_periph_checker.sv */
// --------------------
// Response checker
// Compares OBI responses and counts errors per test
// --------------------

module ao_periph_checker (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        rvalid_i,
  input logic [31:0] rdata_i,
  input logic        err_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] exp_data_q[$];
  logic        exp_err_q[$];
  logic        exp_known_q[$];
  logic [31:0] exp_data;
  logic        exp_err;
  logic        exp_known;
  int          error_cnt;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  string       test_name;

  initial begin
    error_cnt    = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
  end

  // Unknown data is only checked for its error flag
  task automatic expect_rsp(input logic known, input logic [31:0] data, input logic err);
    exp_known_q.push_back(known);
    exp_data_q.push_back(data);
    exp_err_q.push_back(err);
  endtask

  function automatic int pending();
    return exp_data_q.size();
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      error_cnt++;
      test_errors++;
    end
  endtask

  task automatic check_cond(input logic ok, input string what);
    if (ok !== 1'b1) begin
      $display("Check failed: %s", what);
      error_cnt++;
      test_errors++;
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_n_i && rvalid_i) begin
      if (exp_data_q.size() == 0) begin
        check_cond(1'b0, "OBI response arrived with no access outstanding");
      end else begin
        exp_known = exp_known_q.pop_front();
        exp_data  = exp_data_q.pop_front();
        exp_err   = exp_err_q.pop_front();
        check_value("obi_err_o", {31'b0, err_i}, {31'b0, exp_err});
        if (exp_known) check_value("obi_rdata_o", rdata_i, exp_data);
      end
    end
  end

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %0d (%s) passed", tests_run, test_name);
    end else begin
      tests_failed++;
      $display("Test %0d (%s) FAILED with %0d errors", tests_run, test_name, test_errors);
    end
  endtask

  task automatic report(input int unsigned assert_fails);
    if (exp_data_q.size() != 0) begin
      $display("Check failed: %0d expected responses never arrived", exp_data_q.size());
      error_cnt++;
    end
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors, %0d assertion failures",
             tests_run, tests_run - tests_failed, tests_failed, error_cnt, assert_fails);
  endtask

endmodule

/* verif/ao_periph_props.sv */
// --------------------
// OBI handshake and power output properties
// --------------------

module ao_periph_props (
  input logic clk_i,
  input logic rst_n_i,
  input logic req_i,
  input logic gnt_i,
  input logic rvalid_i,
  input logic exit_valid_i,
  input logic switch_i,
  input logic cpu_rst_n_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;

  gnt_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i) gnt_i == req_i)
    else begin
      $error("OBI grant differs from the request");
      fail_cnt++;
    end

  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i) gnt_i |=> rvalid_i)
    else begin
      $error("No response one cycle after a grant");
      fail_cnt++;
    end

  rvalid_needs_gnt: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rvalid_i |-> $past(gnt_i))
    else begin
      $error("Response without a grant in the previous cycle");
      fail_cnt++;
    end

  // CPU must be held in reset while its power is off
  switch_holds_reset: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) switch_i |-> !cpu_rst_n_i)
    else begin
      $error("Power switch on while CPU reset is released");
      fail_cnt++;
    end

  reset_outputs: assert property (
    @(posedge clk_i) $rose(rst_n_i) |-> !exit_valid_i && cpu_rst_n_i)
    else begin
      $error("Outputs not at their reset values after reset");
      fail_cnt++;
    end

endmodule

/* verif/ao_periph_tb.sv */
// --------------------
// Always-on subsystem testbench
// Random OBI traffic against a register model
// --------------------

module ao_periph_tb
  import ao_bus_pkg::*;
  import ao_periph_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_RW  = 6;
  localparam int N_ERR = 24;
  // Planned cycles per test
  localparam int T_RW   = N_RW * 12 + 8;
  localparam int T_ERR  = N_ERR + 12;
  localparam int T_EXIT = 16;
  localparam int T_TMR  = 9 * 4 + 20;
  localparam int T_PWR  = 64;
  localparam int TIMEOUT_CYC = 4 * (T_RW + T_ERR + T_EXIT + T_TMR + T_PWR);

  logic        clk;
  logic        rst_n;
  logic        obi_req;
  logic [31:0] obi_addr;
  logic        obi_we;
  logic [31:0] obi_wdata;
  logic        obi_gnt;
  logic        obi_rvalid;
  logic [31:0] obi_rdata;
  logic        obi_err;
  logic        boot_select;
  logic        exit_valid;
  logic [31:0] exit_value;
  logic        core_sleep;
  logic        cpu_switch;
  logic        cpu_rst_n;
  logic        timer_irq;
  int unsigned cycle_cnt;

  // Register model
  logic        m_exit_valid;
  logic [31:0] m_exit_value;
  logic [31:0] m_scratch;
  logic        m_tmr_en;
  logic [31:0] m_prescale;
  logic [31:0] m_mtimecmp;
  logic        m_pwr_en;
  logic [31:0] m_wake_delay;

  tb_clk_gen clk_gen0 (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ao_periph dut0 (
    .clk_i                  (clk),
    .rst_n_i                (rst_n),
    .obi_req_i              (obi_req),
    .obi_addr_i             (obi_addr),
    .obi_we_i               (obi_we),
    .obi_wdata_i            (obi_wdata),
    .obi_gnt_o              (obi_gnt),
    .obi_rvalid_o           (obi_rvalid),
    .obi_rdata_o            (obi_rdata),
    .obi_err_o              (obi_err),
    .boot_select_i          (boot_select),
    .exit_valid_o           (exit_valid),
    .exit_value_o           (exit_value),
    .core_sleep_i           (core_sleep),
    .cpu_powergate_switch_o (cpu_switch),
    .cpu_rst_no             (cpu_rst_n),
    .timer_irq_o            (timer_irq)
  );

  ao_periph_checker chk0 (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .rvalid_i (obi_rvalid),
    .rdata_i  (obi_rdata),
    .err_i    (obi_err)
  );

  bind ao_periph ao_periph_props props0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (obi_req_i),
    .gnt_i        (obi_gnt_o),
    .rvalid_i     (obi_rvalid_o),
    .exit_valid_i (exit_valid_o),
    .switch_i     (cpu_powergate_switch_o),
    .cpu_rst_n_i  (cpu_rst_no)
  );

  function automatic logic [31:0] reg_addr(input logic [3:0] region, input logic [5:0] offs);
    return {16'h0000, region, 4'h0, offs, 2'b00};
  endfunction

  // Expected response from the register map, updating the model on a legal write
  function automatic void model_access(input logic we, input logic [31:0] addr,
                                       input logic [31:0] wdata, output logic known,
                                       output logic [31:0] rd, output logic err);
    logic [5:0] offs;
    logic       wr_ok;
    offs  = addr[7:2];
    known = 1'b1;
    rd    = '0;
    err   = 1'b0;
    case (addr[15:12])
      REGION_SOC_CTRL: begin
        case (offs)
          SOC_EXIT_VALID: rd = {31'b0, m_exit_valid};
          SOC_EXIT_VALUE: rd = m_exit_value;
          SOC_BOOT_SEL:   rd = {31'b0, boot_select};
          SOC_SCRATCH:    rd = m_scratch;
          default:        err = 1'b1;
        endcase
        err   = err || (we && offs == SOC_BOOT_SEL);
        wr_ok = we && !err;
        if (wr_ok && offs == SOC_EXIT_VALID) m_exit_valid = m_exit_valid | wdata[0];
        if (wr_ok && offs == SOC_EXIT_VALUE) m_exit_value = wdata;
        if (wr_ok && offs == SOC_SCRATCH) m_scratch = wdata;
      end
      REGION_TIMER: begin
        case (offs)
          TMR_CTRL:     rd = {31'b0, m_tmr_en};
          TMR_PRESCALE: rd = m_prescale;
          // Free-running, checked in the timer test
          TMR_MTIME:    known = 1'b0;
          TMR_MTIMECMP: rd = m_mtimecmp;
          default:      err = 1'b1;
        endcase
        wr_ok = we && !err;
        if (wr_ok && offs == TMR_CTRL) m_tmr_en = wdata[0];
        if (wr_ok && offs == TMR_PRESCALE) m_prescale = wdata;
        if (wr_ok && offs == TMR_MTIMECMP) m_mtimecmp = wdata;
      end
      REGION_POWER: begin
        case (offs)
          PWR_CTRL:       rd = {31'b0, m_pwr_en};
          PWR_WAKE_DELAY: rd = m_wake_delay;
          PWR_STATUS:     known = 1'b0;
          default:        err = 1'b1;
        endcase
        err   = err || (we && offs == PWR_STATUS);
        wr_ok = we && !err;
        if (wr_ok && offs == PWR_CTRL) m_pwr_en = wdata[0];
        if (wr_ok && offs == PWR_WAKE_DELAY) m_wake_delay = wdata;
      end
      default: err = 1'b1;
    endcase
    // Writes and errors carry zero data
    if (we || err) begin
      rd    = '0;
      known = 1'b1;
    end
  endfunction

  // Drives one access and returns after its grant
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata);
    logic        known;
    logic [31:0] rd;
    logic        err;
    model_access(we, addr, wdata, known, rd, err);
    @(negedge clk);
    obi_req   = 1'b1;
    obi_we    = we;
    obi_addr  = addr;
    obi_wdata = wdata;
    chk0.expect_rsp(known, rd, err);
    @(posedge clk);
    while (!obi_gnt) @(posedge clk);
  endtask

  task automatic release_bus();
    @(negedge clk);
    obi_req = 1'b0;
    obi_we  = 1'b0;
  endtask

  task automatic wait_responses();
    release_bus();
    while (chk0.pending() != 0) @(negedge clk);
  endtask

  task automatic write_word(input logic [3:0] region, input logic [5:0] offs,
                            input logic [31:0] data);
    bus_access(1'b1, reg_addr(region, offs), data);
  endtask

  task automatic read_word(input logic [3:0] region, input logic [5:0] offs);
    bus_access(1'b0, reg_addr(region, offs), '0);
  endtask

  // Read whose data the test inspects itself
  task automatic fetch_word(input logic [3:0] region, input logic [5:0] offs,
                            output logic [31:0] data);
    read_word(region, offs);
    release_bus();
    data = obi_rdata;
  endtask

  task automatic register_rw_test();
    chk0.begin_test("register read/write");
    boot_select = $urandom % 2;
    repeat (N_RW) begin
      write_word(REGION_SOC_CTRL, SOC_SCRATCH, $urandom());
      write_word(REGION_TIMER, TMR_PRESCALE, $urandom());
      write_word(REGION_TIMER, TMR_MTIMECMP, $urandom());
      write_word(REGION_POWER, PWR_WAKE_DELAY, $urandom());
      read_word(REGION_SOC_CTRL, SOC_SCRATCH);
      read_word(REGION_TIMER, TMR_PRESCALE);
      read_word(REGION_TIMER, TMR_MTIMECMP);
      read_word(REGION_POWER, PWR_WAKE_DELAY);
      read_word(REGION_SOC_CTRL, SOC_BOOT_SEL);
      // Boot strap changes only while the bus is idle
      wait_responses();
      boot_select = ~boot_select;
    end
    chk0.end_test();
  endtask

  task automatic error_response_test();
    logic [31:0] addr;
    logic [3:0]  region;
    logic        we;
    chk0.begin_test("error responses");
    repeat (N_ERR) begin
      we = $urandom % 2;
      case ($urandom % 3)
        0: begin
          addr          = $urandom();
          addr[15:12]   = 3 + $urandom % 13;
          addr[1:0]     = 2'b00;
        end
        1: begin
          region = $urandom % 3;
          if (region == REGION_POWER) addr = reg_addr(region, 3 + $urandom % 61);
          else addr = reg_addr(region, 4 + $urandom % 60);
        end
        default: begin
          we = 1'b1;
          if ($urandom % 2) addr = reg_addr(REGION_SOC_CTRL, SOC_BOOT_SEL);
          else addr = reg_addr(REGION_POWER, PWR_STATUS);
        end
      endcase
      bus_access(we, addr, $urandom());
    end
    read_word(REGION_SOC_CTRL, SOC_SCRATCH);
    read_word(REGION_SOC_CTRL, SOC_EXIT_VALUE);
    read_word(REGION_SOC_CTRL, SOC_BOOT_SEL);
    read_word(REGION_TIMER, TMR_PRESCALE);
    read_word(REGION_TIMER, TMR_MTIMECMP);
    read_word(REGION_POWER, PWR_WAKE_DELAY);
    read_word(REGION_POWER, PWR_CTRL);
    wait_responses();
    chk0.end_test();
  endtask

  task automatic exit_status_test();
    logic [31:0] value;
    chk0.begin_test("exit status");
    value = $urandom();
    write_word(REGION_SOC_CTRL, SOC_EXIT_VALUE, value);
    write_word(REGION_SOC_CTRL, SOC_EXIT_VALID, 32'd1);
    wait_responses();
    chk0.check_value("exit_value_o", exit_value, value);
    chk0.check_value("exit_valid_o", {31'b0, exit_valid}, 32'd1);
    // Sticky bit ignores later zero writes
    write_word(REGION_SOC_CTRL, SOC_EXIT_VALID, 32'd0);
    write_word(REGION_SOC_CTRL, SOC_EXIT_VALID, 32'd0);
    read_word(REGION_SOC_CTRL, SOC_EXIT_VALID);
    wait_responses();
    chk0.check_value("exit_valid_o", {31'b0, exit_valid}, 32'd1);
    chk0.end_test();
  endtask

  task automatic timer_irq_test();
    logic [31:0] cmp;
    logic [31:0] pre;
    logic [31:0] mtime;
    int          n;
    chk0.begin_test("timer interrupt");
    cmp = 2 + $urandom % 6;
    pre = $urandom % 4;
    write_word(REGION_TIMER, TMR_MTIME, 32'd0);
    write_word(REGION_TIMER, TMR_PRESCALE, pre);
    write_word(REGION_TIMER, TMR_MTIMECMP, cmp);
    wait_responses();
    chk0.check_value("timer_irq_o", {31'b0, timer_irq}, 32'd0);
    write_word(REGION_TIMER, TMR_CTRL, 32'd1);
    release_bus();
    n = 0;
    while (!timer_irq && n < (cmp + 2) * (pre + 1)) begin
      @(negedge clk);
      n++;
    end
    chk0.check_cond(timer_irq, "timer interrupt did not rise in time");
    fetch_word(REGION_TIMER, TMR_MTIME, mtime);
    chk0.check_cond(mtime >= cmp,
                    $sformatf("MTIME 0x%08h read below MTIMECMP 0x%08h", mtime, cmp));
    write_word(REGION_TIMER, TMR_MTIME, 32'd0);
    wait_responses();
    chk0.check_value("timer_irq_o", {31'b0, timer_irq}, 32'd0);
    write_word(REGION_TIMER, TMR_CTRL, 32'd0);
    wait_responses();
    chk0.end_test();
  endtask

  task automatic power_sequence_test();
    logic [31:0] cmp;
    logic [31:0] delay;
    logic [31:0] status;
    int          n;
    chk0.begin_test("power sequencing");
    cmp   = 8 + $urandom % 8;
    delay = 2 + $urandom % 5;
    write_word(REGION_POWER, PWR_WAKE_DELAY, delay);
    write_word(REGION_TIMER, TMR_MTIME, 32'd0);
    write_word(REGION_TIMER, TMR_PRESCALE, 32'd0);
    write_word(REGION_TIMER, TMR_MTIMECMP, cmp);
    write_word(REGION_POWER, PWR_CTRL, 32'd1);
    wait_responses();
    core_sleep = 1'b1;
    n = 0;
    while (!cpu_switch && n < 4) begin
      @(negedge clk);
      n++;
    end
    core_sleep = 1'b0;
    chk0.check_cond(cpu_switch, "power switch did not turn on after the sleep request");
    chk0.check_value("cpu_rst_no", {31'b0, cpu_rst_n}, 32'd0);
    fetch_word(REGION_POWER, PWR_STATUS, status);
    chk0.check_value("PWR_STATUS", status, 32'd1);
    // Timer interrupt is the wake source
    write_word(REGION_TIMER, TMR_CTRL, 32'd1);
    release_bus();
    n = 0;
    while (cpu_switch && n < cmp + 8) begin
      @(negedge clk);
      n++;
    end
    chk0.check_cond(!cpu_switch, "power switch stayed on after the timer interrupt");
    n = 0;
    while (!cpu_rst_n && n < delay + 8) begin
      @(negedge clk);
      n++;
    end
    chk0.check_cond(cpu_rst_n, "CPU reset was not released after wake-up");
    chk0.check_cond(n >= delay,
                    $sformatf("CPU reset released after %0d cycles, wake delay %0d", n, delay));
    fetch_word(REGION_POWER, PWR_STATUS, status);
    chk0.check_value("PWR_STATUS", status, 32'd0);
    write_word(REGION_POWER, PWR_CTRL, 32'd0);
    write_word(REGION_TIMER, TMR_CTRL, 32'd0);
    wait_responses();
    chk0.end_test();
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    void'($urandom(86));
    cycle_cnt    = 0;
    obi_req      = 1'b0;
    obi_addr     = '0;
    obi_we       = 1'b0;
    obi_wdata    = '0;
    boot_select  = 1'b0;
    core_sleep   = 1'b0;
    m_exit_valid = 1'b0;
    m_exit_value = '0;
    m_scratch    = '0;
    m_tmr_en     = 1'b0;
    m_prescale   = '0;
    m_mtimecmp   = MTIMECMP_RST;
    m_pwr_en     = 1'b0;
    m_wake_delay = WAKE_DELAY_RST;
    @(posedge rst_n);
    register_rw_test();
    error_response_test();
    exit_status_test();
    timer_irq_test();
    power_sequence_test();
    chk0.report(dut0.props0.fail_cnt);
    if (chk0.error_cnt == 0 && dut0.props0.fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* verif/tb_clk_gen.sv */
// --------------------
// Testbench clock and reset
// --------------------

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    // 8 ns period
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* verilog/ao_periph.sv */
// --------------------
// Always-on peripheral subsystem
// OBI bridge with SoC control, timer and power manager
// --------------------

module ao_periph
  import ao_bus_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,

  input  logic              obi_req_i,
  input  logic [ADDR_W-1:0] obi_addr_i,
  input  logic              obi_we_i,
  input  logic [DATA_W-1:0] obi_wdata_i,
  output logic              obi_gnt_o,
  output logic              obi_rvalid_o,
  output logic [DATA_W-1:0] obi_rdata_o,
  output logic              obi_err_o,

  // SoC control
  input  logic              boot_select_i,
  output logic              exit_valid_o,
  output logic [DATA_W-1:0] exit_value_o,

  // Power manager
  input  logic              core_sleep_i,
  output logic              cpu_powergate_switch_o,
  output logic              cpu_rst_no,

  output logic              timer_irq_o
);

  reg_bus_if soc_bus ();
  reg_bus_if tmr_bus ();
  reg_bus_if pwr_bus ();

  obi_reg_bridge obi_reg_bridge_i (
    .clk_i,
    .rst_n_i,
    .obi_req_i,
    .obi_addr_i,
    .obi_we_i,
    .obi_wdata_i,
    .obi_gnt_o,
    .obi_rvalid_o,
    .obi_rdata_o,
    .obi_err_o,
    .soc_bus_o (soc_bus),
    .tmr_bus_o (tmr_bus),
    .pwr_bus_o (pwr_bus)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_n_i,
    .bus_i (soc_bus),
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o
  );

  rv_timer rv_timer_i (
    .clk_i,
    .rst_n_i,
    .bus_i (tmr_bus),
    .irq_o (timer_irq_o)
  );

  // Timer interrupt doubles as the wake source
  power_manager power_manager_i (
    .clk_i,
    .rst_n_i,
    .bus_i              (pwr_bus),
    .core_sleep_i,
    .wake_irq_i         (timer_irq_o),
    .powergate_switch_o (cpu_powergate_switch_o),
    .cpu_rst_no
  );

endmodule

/* verilog/obi_reg_bridge.sv */
// --------------------
// OBI to register bus bridge
// Decodes the region and returns one response per grant
// --------------------

module obi_reg_bridge
  import ao_bus_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,

  input  logic              obi_req_i,
  input  logic [ADDR_W-1:0] obi_addr_i,
  input  logic              obi_we_i,
  input  logic [DATA_W-1:0] obi_wdata_i,
  output logic              obi_gnt_o,
  output logic              obi_rvalid_o,
  output logic [DATA_W-1:0] obi_rdata_o,
  output logic              obi_err_o,

  reg_bus_if.host           soc_bus_o,
  reg_bus_if.host           tmr_bus_o,
  reg_bus_if.host           pwr_bus_o
);

  periph_sel_e         sel;
  logic [OFFS_W-1:0]   offs;
  logic [DATA_W-1:0]   rsp_rdata;
  logic                rsp_err;
  logic                rvalid_q;
  logic [DATA_W-1:0]   rdata_q;
  logic                err_q;

  always_comb begin
    case (obi_addr_i[REGION_LSB +: REGION_W])
      REGION_SOC_CTRL: sel = SEL_SOC_CTRL;
      REGION_TIMER:    sel = SEL_TIMER;
      REGION_POWER:    sel = SEL_POWER;
      default:         sel = SEL_NONE;
    endcase
  end

  assign offs = obi_addr_i[OFFS_LSB +: OFFS_W];

  // Responses never stall, so every request is granted at once
  assign obi_gnt_o = obi_req_i;

  assign soc_bus_o.valid = obi_req_i && (sel == SEL_SOC_CTRL);
  assign soc_bus_o.write = obi_we_i;
  assign soc_bus_o.offs  = offs;
  assign soc_bus_o.wdata = obi_wdata_i;

  assign tmr_bus_o.valid = obi_req_i && (sel == SEL_TIMER);
  assign tmr_bus_o.write = obi_we_i;
  assign tmr_bus_o.offs  = offs;
  assign tmr_bus_o.wdata = obi_wdata_i;

  assign pwr_bus_o.valid = obi_req_i && (sel == SEL_POWER);
  assign pwr_bus_o.write = obi_we_i;
  assign pwr_bus_o.offs  = offs;
  assign pwr_bus_o.wdata = obi_wdata_i;

  always_comb begin
    case (sel)
      SEL_SOC_CTRL: {rsp_err, rsp_rdata} = {soc_bus_o.error, soc_bus_o.rdata};
      SEL_TIMER:    {rsp_err, rsp_rdata} = {tmr_bus_o.error, tmr_bus_o.rdata};
      SEL_POWER:    {rsp_err, rsp_rdata} = {pwr_bus_o.error, pwr_bus_o.rdata};
      default:      {rsp_err, rsp_rdata} = {1'b1, {DATA_W{1'b0}}};
    endcase
    // Writes and errors return zero data
    if (obi_we_i || rsp_err) begin
      rsp_rdata = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= obi_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (obi_req_i) begin
      rdata_q <= rsp_rdata;
      err_q   <= rsp_err;
    end
  end

  assign obi_rvalid_o = rvalid_q;
  assign obi_rdata_o  = rdata_q;
  assign obi_err_o    = err_q;

endmodule

/* verilog/soc_ctrl.sv */
// --------------------
// SoC control registers
// Exit status, boot select and scratch word
// --------------------

module soc_ctrl
  import ao_bus_pkg::*;
  import ao_periph_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  reg_bus_if.device         bus_i,
  input  logic              boot_select_i,
  output logic              exit_valid_o,
  output logic [DATA_W-1:0] exit_value_o
);

  logic              exit_valid_q;
  logic [DATA_W-1:0] exit_value_q;
  logic [DATA_W-1:0] scratch_q;
  logic [DATA_W-1:0] rdata;
  logic              err;
  logic              wr_en;

  always_comb begin
    rdata = '0;
    err   = 1'b0;
    case (bus_i.offs)
      SOC_EXIT_VALID: rdata = {{(DATA_W-1){1'b0}}, exit_valid_q};
      SOC_EXIT_VALUE: rdata = exit_value_q;
      SOC_BOOT_SEL: begin
        rdata = {{(DATA_W-1){1'b0}}, boot_select_i};
        err   = bus_i.write;
      end
      SOC_SCRATCH:    rdata = scratch_q;
      default:        err = 1'b1;
    endcase
  end

  assign wr_en = bus_i.valid && bus_i.write && !err;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      scratch_q    <= '0;
    end else if (wr_en) begin
      case (bus_i.offs)
        // Sticky until reset
        SOC_EXIT_VALID: exit_valid_q <= exit_valid_q | bus_i.wdata[0];
        SOC_EXIT_VALUE: exit_value_q <= bus_i.wdata;
        SOC_SCRATCH:    scratch_q    <= bus_i.wdata;
        default:        ;
      endcase
    end
  end

  assign bus_i.rdata  = rdata;
  assign bus_i.error  = err;
  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule
